//--- dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    localparam int XLEN       = 32;             // Data and PC width
    localparam int REG_ADDR_W = 5;              // 32 architectural registers

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,                        // Signed compare
        ALU_SLTU = 4'd3,                        // Unsigned compare
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11                        // Passes the immediate through
    } alu_op_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rdata1;          // Register file read values
        logic [XLEN-1:0]       rdata2;
        logic [XLEN-1:0]       imm;
        alu_op_t               alu_op;
        logic                  src1_pc;         // Operand 1 is the PC
        logic                  src2_imm;        // Operand 2 is the immediate
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] waddr;
    } issue_slot_t;

    // Shared by the EX/MEM and MEM/WB registers
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } stage_result_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
    } operand_pair_t;

endpackage

`default_nettype wire

//--- operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import dual_issue_pkg::*; #(
    parameter int NUM_LANES = 2
) (
    input  wire issue_slot_t   slots     [NUM_LANES],
    input  wire stage_result_t mem_stage [NUM_LANES],
    input  wire stage_result_t wb_stage  [NUM_LANES],
    output operand_pair_t      operands  [NUM_LANES]
);

    function automatic logic producer_hit(stage_result_t s, logic [REG_ADDR_W-1:0] raddr);
        return s.valid && s.rf_we && (s.waddr == raddr);
    endfunction

    // Lowest priority first, so the last match to land is the youngest producer
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            operands[i].op1 = slots[i].rdata1;                    // No producer, use RF
            operands[i].op2 = slots[i].rdata2;
            for (int j = 0; j < NUM_LANES; j++) begin             // WB, older lanes first
                if (producer_hit(wb_stage[j], slots[i].rs1)) begin
                    operands[i].op1 = wb_stage[j].wdata;
                end
                if (producer_hit(wb_stage[j], slots[i].rs2)) begin
                    operands[i].op2 = wb_stage[j].wdata;
                end
            end
            for (int j = 0; j < NUM_LANES; j++) begin             // MEM beats any WB
                if (producer_hit(mem_stage[j], slots[i].rs1)) begin
                    operands[i].op1 = mem_stage[j].wdata;
                end
                if (producer_hit(mem_stage[j], slots[i].rs2)) begin
                    operands[i].op2 = mem_stage[j].wdata;
                end
            end
        end
    end

    // Lanes drop r0 writes, so r0 reads always come from the register file
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (slots[i].valid) begin
                assert ((slots[i].rs1 != '0 || operands[i].op1 == slots[i].rdata1) &&
                        (slots[i].rs2 != '0 || operands[i].op2 == slots[i].rdata2))
                    else $error("operand_forward: lane %0d bypassed a write to r0", i);
            end
        end
    end

endmodule

`default_nettype wire

//--- exec_lane.sv
`timescale 1ns/1ps
`default_nettype none

module exec_lane import dual_issue_pkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          stall,            // Freezes both stage registers
    input  wire logic          flush,            // Empties both stage registers
    input  wire issue_slot_t   slot,
    input  wire operand_pair_t operands,         // Already forwarded
    output stage_result_t      mem_stage,        // EX/MEM register
    output stage_result_t      wb_stage          // MEM/WB register
);

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_result;
    stage_result_t   ex_result;

    assign alu_a = slot.src1_pc ? slot.pc : operands.op1;
    assign alu_b = slot.src2_imm ? slot.imm : operands.op2;
    assign shamt = alu_b[4:0];                   // Shift amount from operand 2

    always_comb begin
        case (slot.alu_op)
            ALU_ADD: begin
                alu_result = alu_a + alu_b;
            end
            ALU_SUB: begin
                alu_result = alu_a - alu_b;
            end
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            end
            ALU_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, alu_a < alu_b};
            end
            ALU_AND: begin
                alu_result = alu_a & alu_b;
            end
            ALU_OR: begin
                alu_result = alu_a | alu_b;
            end
            ALU_XOR: begin
                alu_result = alu_a ^ alu_b;
            end
            ALU_NOR: begin
                alu_result = ~(alu_a | alu_b);
            end
            ALU_SLL: begin
                alu_result = alu_a << shamt;
            end
            ALU_SRL: begin
                alu_result = alu_a >> shamt;
            end
            ALU_SRA: begin
                alu_result = $signed(alu_a) >>> shamt;
            end
            ALU_LUI: begin
                alu_result = slot.imm;           // Decoder has already shifted it
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    always_comb begin
        ex_result.valid = slot.valid;
        ex_result.pc    = slot.pc;
        ex_result.rf_we = slot.rf_we && (slot.waddr != '0);  // r0 is hardwired zero
        ex_result.waddr = slot.waddr;
        ex_result.wdata = alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin                // Flush wins over stall
            mem_stage.valid <= 1'b0;
            wb_stage.valid  <= 1'b0;
        end else if (!stall) begin
            mem_stage <= ex_result;
            wb_stage  <= mem_stage;
        end
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        mem_stage.valid |-> !(mem_stage.rf_we && mem_stage.waddr == '0))
        else $error("exec_lane: EX/MEM holds a write to r0");

    a_flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !mem_stage.valid && !wb_stage.valid)
        else $error("exec_lane: stage still valid after flush");

endmodule

`default_nettype wire

//--- writeback_commit.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_commit import dual_issue_pkg::*; #(
    parameter int NUM_LANES = 2
) (
    input  wire logic          stall,
    input  wire stage_result_t wb_stage  [NUM_LANES],
    output rf_write_t          rf_writes [NUM_LANES],
    output logic [XLEN-1:0]    commit_pc [NUM_LANES]
);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rf_writes[i].we    = wb_stage[i].valid && wb_stage[i].rf_we && !stall;
            rf_writes[i].waddr = wb_stage[i].waddr;
            rf_writes[i].wdata = wb_stage[i].wdata;
            commit_pc[i]       = wb_stage[i].pc;               // Debug trace of the WB pc
            // A younger lane to the same register makes this write dead
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (wb_stage[j].valid && wb_stage[j].rf_we &&
                    wb_stage[j].waddr == wb_stage[i].waddr) begin
                    rf_writes[i].we = 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (rf_writes[i].we && rf_writes[j].we) begin
                    assert (rf_writes[i].waddr != rf_writes[j].waddr)
                        else $error("writeback_commit: lanes %0d and %0d both write r%0d",
                                    i, j, rf_writes[i].waddr);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ex_mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_wb_top import dual_issue_pkg::*; #(
    parameter int NUM_LANES = 2                  // Lane 0 is the oldest
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          stall,
    input  wire logic          flush,
    input  wire issue_slot_t   slots     [NUM_LANES],
    output rf_write_t          rf_writes [NUM_LANES],
    output logic [XLEN-1:0]    commit_pc [NUM_LANES]
);

    operand_pair_t operands  [NUM_LANES];
    stage_result_t mem_stage [NUM_LANES];
    stage_result_t wb_stage  [NUM_LANES];

    operand_forward #(
        .NUM_LANES (NUM_LANES)
    ) fwd_i (
        .slots     (slots),
        .mem_stage (mem_stage),
        .wb_stage  (wb_stage),
        .operands  (operands)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exec_lane lane_i (
            .clk       (clk),
            .reset     (reset),
            .stall     (stall),
            .flush     (flush),
            .slot      (slots[i]),
            .operands  (operands[i]),
            .mem_stage (mem_stage[i]),
            .wb_stage  (wb_stage[i])
        );
    end

    writeback_commit #(
        .NUM_LANES (NUM_LANES)
    ) commit_i (
        .stall     (stall),
        .wb_stage  (wb_stage),
        .rf_writes (rf_writes),
        .commit_pc (commit_pc)
    );

endmodule

`default_nettype wire

//--- tb_ex_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_mem_wb import dual_issue_pkg::*; ();

    localparam int LANES     = 2;
    localparam int ALU_CYC   = 12 * 4 + 3;
    localparam int FWD_CYC   = 40 + 3;
    localparam int R0_CYC    = 8 * 3 + 3;
    localparam int WAW_CYC   = 8 * 3 + 3;
    localparam int STALL_CYC = 24 * 6 + 3;
    localparam int FLUSH_CYC = 12 * 6 + 3;
    localparam int TOTAL_CYC = 8 + ALU_CYC + FWD_CYC + R0_CYC + WAW_CYC + STALL_CYC + FLUSH_CYC;
    localparam int TIMEOUT_NS = TOTAL_CYC * 4 + 400;
    localparam issue_slot_t BUBBLE = '0;

    logic            clk;
    logic            reset;
    logic            stall;
    logic            flush;
    issue_slot_t     slots     [LANES];
    rf_write_t       rf_writes [LANES];
    logic [XLEN-1:0] commit_pc [LANES];

    stage_result_t   m_mem [LANES];               // Reference EX/MEM
    stage_result_t   m_wb  [LANES];               // Reference MEM/WB
    logic            exp_we [LANES];
    logic [31:0]     rng_state = 32'h7edfd08a;
    int              errors = 0;
    int              start_errors = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;

    ex_mem_wb_top #(.NUM_LANES(LANES)) dut_i (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .slots     (slots),
        .rf_writes (rf_writes),
        .commit_pc (commit_pc)
    );

    always #2 clk = ~clk;

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] ref_alu(alu_op_t op, logic [31:0] a, logic [31:0] b,
                                            logic [31:0] imm);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return imm;                   // LUI
        endcase
    endfunction

    // Youngest producer first, MEM before WB
    function automatic logic [31:0] ref_operand(logic [4:0] raddr, logic [31:0] rdata);
        for (int j = LANES - 1; j >= 0; j--) begin
            if (m_mem[j].valid && m_mem[j].rf_we && m_mem[j].waddr == raddr) begin
                return m_mem[j].wdata;
            end
        end
        for (int j = LANES - 1; j >= 0; j--) begin
            if (m_wb[j].valid && m_wb[j].rf_we && m_wb[j].waddr == raddr) begin
                return m_wb[j].wdata;
            end
        end
        return rdata;
    endfunction

    function automatic stage_result_t ref_execute(issue_slot_t s);
        stage_result_t r;
        logic [31:0]   op1;
        logic [31:0]   op2;
        op1 = s.src1_pc ? s.pc : ref_operand(s.rs1, s.rdata1);
        op2 = s.src2_imm ? s.imm : ref_operand(s.rs2, s.rdata2);
        r.valid = s.valid;
        r.pc    = s.pc;
        r.rf_we = s.rf_we && (s.waddr != 5'd0);
        r.waddr = s.waddr;
        r.wdata = ref_alu(s.alu_op, op1, op2, s.imm);
        return r;
    endfunction

    always @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (reset || flush) begin
                m_mem[i].valid <= 1'b0;
                m_wb[i].valid  <= 1'b0;
            end else if (!stall) begin
                m_mem[i] <= ref_execute(slots[i]);
                m_wb[i]  <= m_mem[i];
            end
        end
    end

    always_comb begin
        exp_we[1] = m_wb[1].valid && m_wb[1].rf_we && !stall;
        exp_we[0] = m_wb[0].valid && m_wb[0].rf_we && !stall &&
                    !(m_wb[1].valid && m_wb[1].rf_we && m_wb[1].waddr == m_wb[0].waddr);
    end

    for (genvar i = 0; i < LANES; i++) begin : g_chk
        a_we: assert property (@(posedge clk) disable iff (reset)
            rf_writes[i].we == exp_we[i])
            else begin
                errors++;
                $display("** Error: rf_writes[%0d].we expected %h got %h", i,
                         $sampled(exp_we[i]), $sampled(rf_writes[i].we));
            end
        a_waddr: assert property (@(posedge clk) disable iff (reset)
            exp_we[i] |-> rf_writes[i].waddr == m_wb[i].waddr)
            else begin
                errors++;
                $display("** Error: rf_writes[%0d].waddr expected %h got %h", i,
                         $sampled(m_wb[i].waddr), $sampled(rf_writes[i].waddr));
            end
        a_wdata: assert property (@(posedge clk) disable iff (reset)
            exp_we[i] |-> rf_writes[i].wdata == m_wb[i].wdata)
            else begin
                errors++;
                $display("** Error: rf_writes[%0d].wdata expected %h got %h", i,
                         $sampled(m_wb[i].wdata), $sampled(rf_writes[i].wdata));
            end
        a_pc: assert property (@(posedge clk) disable iff (reset)
            m_wb[i].valid |-> commit_pc[i] == m_wb[i].pc)
            else begin
                errors++;
                $display("** Error: commit_pc[%0d] expected %h got %h", i,
                         $sampled(m_wb[i].pc), $sampled(commit_pc[i]));
            end
        a_r0: assert property (@(posedge clk) disable iff (reset)
            !(rf_writes[i].we && rf_writes[i].waddr == 5'd0))
            else begin
                errors++;
                $display("Lane %0d raised a write enable for register r0", i);
            end
    end

    function automatic issue_slot_t rand_slot(logic [3:0] op, logic sel_pc, logic sel_imm,
                                              logic [4:0] amask);
        issue_slot_t s;
        logic [31:0] r;
        r = next_rand();
        s.valid    = 1'b1;
        s.pc       = {r[31:2], 2'b00};
        s.rs1      = r[4:0] & amask;
        s.rs2      = r[9:5] & amask;
        s.waddr    = r[14:10] & amask;
        s.rf_we    = r[15] | r[16];               // Mostly writers
        s.src1_pc  = sel_pc;
        s.src2_imm = sel_imm;
        s.alu_op   = alu_op_t'(op);
        s.rdata1   = (s.rs1 == 5'd0) ? 32'd0 : next_rand();
        s.rdata2   = (s.rs2 == 5'd0) ? 32'd0 : next_rand();
        s.imm      = next_rand();
        return s;
    endfunction

    // Lane B must not read what lane A of the same packet writes
    function automatic issue_slot_t decouple(issue_slot_t b, issue_slot_t a);
        if (a.rf_we && a.waddr != 5'd0) begin
            if (b.rs1 == a.waddr) b.rs1 = a.waddr + 5'd1;
            if (b.rs2 == a.waddr) b.rs2 = a.waddr + 5'd1;
        end
        return b;
    endfunction

    function automatic issue_slot_t any_slot(logic [4:0] amask);
        logic [31:0] r;
        r = next_rand();
        return rand_slot(4'(r % 32'd12), r[20], r[21], amask);
    endfunction

    task automatic drive(issue_slot_t a, issue_slot_t b, logic st, logic fl);
        @(negedge clk);
        slots[0] = a;
        slots[1] = decouple(b, a);
        stall    = st;
        flush    = fl;
    endtask

    task automatic idle(int n);
        repeat (n) drive(BUBBLE, BUBBLE, 1'b0, 1'b0);
    endtask

    task automatic finish_test(string name);
        idle(3);                                  // Drain both stages
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check errors", name, errors - start_errors);
        end
        start_errors = errors;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        issue_slot_t a;
        issue_slot_t b;
        int          n;
        clk      = 1'b0;
        reset    = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        slots[0] = BUBBLE;
        slots[1] = BUBBLE;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int op = 0; op < 12; op++) begin     // Every op and operand source
            for (int sel = 0; sel < 4; sel++) begin
                a = rand_slot(4'(op), sel[1], sel[0], 5'h7);
                b = rand_slot(4'(op), sel[0], sel[1], 5'h7);
                drive(a, b, 1'b0, 1'b0);
            end
        end
        finish_test("alu_ops");

        for (int k = 0; k < 40; k++) begin        // Narrow range, many matches
            drive(any_slot(5'h3), any_slot(5'h3), 1'b0, 1'b0);
        end
        finish_test("forwarding");

        for (int k = 0; k < 8; k++) begin
            a = any_slot(5'h7);
            a.waddr = 5'd0;
            a.rf_we = 1'b1;
            drive(a, any_slot(5'h7), 1'b0, 1'b0);
            a = any_slot(5'h0);                   // Readers of r0
            b = any_slot(5'h0);
            drive(a, b, 1'b0, 1'b0);
            drive(any_slot(5'h0), any_slot(5'h0), 1'b0, 1'b0);
        end
        finish_test("r0_writes");

        for (int k = 0; k < 8; k++) begin
            a = any_slot(5'h7);
            b = any_slot(5'h7);
            a.rf_we = 1'b1;
            a.waddr = 5'd1 + 5'(k % 7);
            b.rf_we = 1'b1;
            b.waddr = a.waddr;
            drive(a, b, 1'b0, 1'b0);
            a = any_slot(5'h7);
            a.rs1 = b.waddr;
            a.src1_pc = 1'b0;                     // Operand 1 from the register
            drive(a, any_slot(5'h7), 1'b0, 1'b0);
            b = any_slot(5'h7);
            b.rs2 = a.rs1;                        // Now from WB
            b.src2_imm = 1'b0;
            drive(any_slot(5'h7), b, 1'b0, 1'b0);
        end
        finish_test("same_dest");

        for (int k = 0; k < 24; k++) begin
            a = any_slot(5'h3);
            b = any_slot(5'h3);
            n = int'(next_rand() % 32'd6);
            repeat (n) drive(a, b, 1'b1, 1'b0);   // Slot held while stalled
            drive(a, b, 1'b0, 1'b0);
        end
        finish_test("stall");

        for (int k = 0; k < 12; k++) begin
            drive(any_slot(5'h3), any_slot(5'h3), 1'b0, 1'b0);
            drive(any_slot(5'h3), any_slot(5'h3), 1'b0, 1'b0);
            drive(BUBBLE, BUBBLE, k[0], 1'b1);    // Odd rounds flush under stall
            idle(2);
            drive(any_slot(5'h3), any_slot(5'h3), 1'b0, 1'b0);
        end
        finish_test("flush");

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
dual_issue_pkg.sv
operand_forward.sv
exec_lane.sv
writeback_commit.sv
ex_mem_wb_top.sv
tb_ex_mem_wb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_ex_mem_wb -f src.f || exit 1
sim_out="$(./obj_dir/Vtb_ex_mem_wb 2>&1)"
printf '%s\n' "$sim_out"
grep -qx "TESTS PASSED" <<< "$sim_out" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
